//--- fdiv_pkg.sv
package fdiv_pkg;

	//////////////////////////////
	// operand classification
	//////////////////////////////

	// class of one significand after capture
	typedef enum logic [1:0] {
		cls_zero,	// all bits clear
		cls_dnrm,	// integer bit clear, some lower bit set
		cls_norm	// integer bit set
	} fdiv_cls_e;

	//////////////////////////////
	// divide iterator
	//////////////////////////////

	// restoring loop control
	typedef enum logic [1:0] {
		st_idle,	// waiting for normalized operands
		st_run,		// one quotient bit per cycle
		st_done		// quotient and remainder flag valid
	} fdiv_iter_st_e;

	//////////////////////////////
	// widths
	//////////////////////////////

	// bits needed to hold a count of 0 .. frac_w+1
	// used for leading zeros and the iteration counter
	function automatic int fdiv_cnt_w(input int frac_w);
		return $clog2(frac_w + 2);
	endfunction

	// lz_diff is one bit wider than the count, signed
	// exponent adjustment is two bits wider, signed

endpackage

//--- fdiv_lead0.sv
`timescale 1ns/1ps

module fdiv_lead0
	import fdiv_pkg::*;
#(
	parameter int FRAC_W = 52,			// fraction bits, integer bit extra
	localparam int CW = fdiv_cnt_w(FRAC_W)		// count width
) (
	input  logic [FRAC_W:0]	i_din,			// significand, integer bit on top
	output logic [CW-1:0]	o_lead0			// zeros above the first one
);

	//////////////////////////////
	// priority scan from the msb
	//////////////////////////////

	// first set bit seen from the top wins
	// nothing set leaves the full width
	always_comb begin
		logic found;				// a one already seen above

		found = 1'b0;
		o_lead0 = CW'(FRAC_W + 1);		// all zero input
		for (int i = FRAC_W; i >= 0; i--) begin
			if (!found && i_din[i]) begin
				o_lead0 = CW'(FRAC_W - i);	// bits above position i
				found = 1'b1;
			end
		end
	end

	// a count of zero means the integer bit is set
	// a count of FRAC_W+1 means the operand is zero
	// anything between is a denormal needing a left shift

endmodule

//--- fdiv_norm_stage.sv
`timescale 1ns/1ps

module fdiv_norm_stage
	import fdiv_pkg::*;
#(
	parameter int FRAC_W = 52,			// fraction bits
	localparam int CW = fdiv_cnt_w(FRAC_W)		// lead zero count width
) (
	input  logic			rclk,		// global clock
	input  logic			i_rst_n,	// sync reset, active low
	input  logic			i_start,	// start strobe
	input  logic			i_busy,		// pipeline occupied
	input  logic [FRAC_W:0]		i_frac_a,	// dividend significand
	input  logic [FRAC_W:0]		i_frac_b,	// divisor significand
	output logic			o_pend,		// capture regs hold an op
	output logic			o_vld,		// normalized operands valid
	output logic [FRAC_W:0]		o_norm_a,	// dividend, top bit set
	output logic [FRAC_W:0]		o_norm_b,	// divisor, top bit set
	output logic signed [CW:0]	o_lz_diff,	// lz(b) - lz(a)
	output fdiv_cls_e		o_cls_a,	// dividend class
	output fdiv_cls_e		o_cls_b		// divisor class
);

	logic			start_acc;	// start seen while idle
	logic [FRAC_W:0]	a_r;		// captured dividend
	logic [FRAC_W:0]	b_r;		// captured divisor
	fdiv_cls_e		cls_a_r;	// captured dividend class
	fdiv_cls_e		cls_b_r;	// captured divisor class
	logic [CW-1:0]		lz_a;		// dividend lead zeros
	logic [CW-1:0]		lz_b;		// divisor lead zeros

	// zero, integer bit clear, or normal
	function automatic fdiv_cls_e classify(input logic [FRAC_W:0] frac);
		if (frac == '0)
			return cls_zero;
		else if (!frac[FRAC_W])
			return cls_dnrm;
		else
			return cls_norm;
	endfunction

	assign start_acc = i_start & ~i_busy;	// starts while busy are dropped

	//////////////////////////////
	// capture
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n)
			o_pend <= 1'b0;
		else
			o_pend <= start_acc;		// one cycle in capture
	end

	always_ff @(posedge rclk) begin
		if (start_acc) begin
			a_r <= i_frac_a;
			b_r <= i_frac_b;
			cls_a_r <= classify(i_frac_a);
			cls_b_r <= classify(i_frac_b);
		end
	end

	//////////////////////////////
	// normalize
	//////////////////////////////

	fdiv_lead0 #(.FRAC_W(FRAC_W)) u_lead0_a (
		.i_din		(a_r),
		.o_lead0	(lz_a)
	);

	fdiv_lead0 #(.FRAC_W(FRAC_W)) u_lead0_b (
		.i_din		(b_r),
		.o_lead0	(lz_b)
	);

	always_ff @(posedge rclk) begin
		if (!i_rst_n)
			o_vld <= 1'b0;
		else
			o_vld <= o_pend;		// second cycle after start
	end

	always_ff @(posedge rclk) begin
		if (o_pend) begin
			o_norm_a <= a_r << lz_a;	// zero stays zero
			o_norm_b <= b_r << lz_b;
			o_lz_diff <= $signed({1'b0, lz_b}) - $signed({1'b0, lz_a});
			o_cls_a <= cls_a_r;
			o_cls_b <= cls_b_r;
		end
	end

	// one op in flight, so valid can never repeat back to back
	a_vld_single: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_vld |=> !o_vld)
		else $error("norm valid pulsed on consecutive cycles");

endmodule

//--- fdiv_iter_stage.sv
`timescale 1ns/1ps

module fdiv_iter_stage
	import fdiv_pkg::*;
#(
	parameter int FRAC_W = 52,			// fraction bits
	localparam int CW = fdiv_cnt_w(FRAC_W)		// counter width
) (
	input  logic			rclk,		// global clock
	input  logic			i_rst_n,	// sync reset, active low
	input  logic			i_pend,		// op in capture stage
	input  logic			i_vld,		// normalized operands valid
	input  logic [FRAC_W:0]		i_norm_a,	// dividend
	input  logic [FRAC_W:0]		i_norm_b,	// divisor
	input  logic signed [CW:0]	i_lz_diff,	// lead zero difference
	input  fdiv_cls_e		i_cls_a,	// dividend class
	input  fdiv_cls_e		i_cls_b,	// divisor class
	output logic			o_busy,		// op anywhere in the pipe
	output logic			o_vld,		// quotient valid pulse
	output logic [FRAC_W+1:0]	o_q,		// quotient, msb weight 1
	output logic			o_rem_nz,	// final remainder nonzero
	output logic signed [CW:0]	o_lz_diff,	// carried along
	output fdiv_cls_e		o_cls_a,	// carried along
	output fdiv_cls_e		o_cls_b		// carried along
);

	fdiv_iter_st_e		st_r;		// loop state
	logic [CW-1:0]		cnt_r;		// quotient bits still to go
	logic [FRAC_W+1:0]	rem_r;		// partial remainder, doubled
	logic [FRAC_W:0]	div_r;		// held divisor
	logic [FRAC_W+1:0]	step_rem;	// remainder into this step
	logic [FRAC_W:0]	step_div;	// divisor into this step
	logic			step_ge;	// quotient bit
	logic [FRAC_W+1:0]	step_diff;	// remainder after restore

	// pending flag from the norm stage covers the capture cycle
	assign o_busy = i_pend | i_vld | (st_r != st_idle);

	//////////////////////////////
	// shift and subtract step
	//////////////////////////////

	// first bit is taken straight from the inputs in the load cycle
	always_comb begin
		step_rem = (st_r == st_idle) ? {1'b0, i_norm_a} : rem_r;
		step_div = (st_r == st_idle) ? i_norm_b : div_r;
		step_ge = step_rem >= {1'b0, step_div};
		step_diff = step_ge ? step_rem - {1'b0, step_div} : step_rem;	// restore
	end

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			st_r <= st_idle;
			cnt_r <= '0;
			o_vld <= 1'b0;
		end else begin
			o_vld <= 1'b0;
			case (st_r)
				st_idle: if (i_vld) begin
					st_r <= st_run;
					cnt_r <= CW'(FRAC_W + 1);	// one bit already out
				end
				st_run: begin
					cnt_r <= cnt_r - 1'b1;
					if (cnt_r == CW'(1)) begin	// last quotient bit
						st_r <= st_done;
						o_vld <= 1'b1;
					end
				end
				st_done: st_r <= st_idle;
				default: st_r <= st_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge rclk) begin
		if (st_r == st_idle && i_vld) begin
			div_r <= i_norm_b;
			rem_r <= {step_diff[FRAC_W:0], 1'b0};
			o_q <= {{(FRAC_W+1){1'b0}}, step_ge};
			o_lz_diff <= i_lz_diff;
			o_cls_a <= i_cls_a;
			o_cls_b <= i_cls_b;
		end else if (st_r == st_run) begin
			rem_r <= {step_diff[FRAC_W:0], 1'b0};
			o_q <= {o_q[FRAC_W:0], step_ge};	// bits shift in from lsb
			if (cnt_r == CW'(1))
				o_rem_nz <= |step_diff;		// sticky source
		end
	end

	a_vld_idle: assert property (@(posedge rclk) disable iff (!i_rst_n)
		i_vld |-> st_r == st_idle)
		else $error("operands arrived while divide loop active");

	// divisor zero only on a div by zero, result dropped later
	a_rem_bound: assert property (@(posedge rclk) disable iff (!i_rst_n)
		(st_r == st_run && div_r != '0) |-> rem_r < {div_r, 1'b0})
		else $error("partial remainder not below twice the divisor");

endmodule

//--- fdiv_round_stage.sv
`timescale 1ns/1ps

module fdiv_round_stage
	import fdiv_pkg::*;
#(
	parameter int FRAC_W = 52,			// fraction bits
	localparam int CW = fdiv_cnt_w(FRAC_W)		// lead zero count width
) (
	input  logic			rclk,		// global clock
	input  logic			i_rst_n,	// sync reset, active low
	input  logic			i_vld,		// quotient valid
	input  logic [FRAC_W+1:0]	i_q,		// raw quotient
	input  logic			i_rem_nz,	// remainder nonzero
	input  logic signed [CW:0]	i_lz_diff,	// lz(b) - lz(a)
	input  fdiv_cls_e		i_cls_a,	// dividend class
	input  fdiv_cls_e		i_cls_b,	// divisor class
	output logic			o_done,		// result valid pulse
	output logic [FRAC_W:0]		o_frac_q,	// rounded significand
	output logic signed [CW+1:0]	o_exp_adj,	// exponent adjustment
	output logic			o_dz,		// divide by zero
	output logic			o_zero		// zero result
);

	logic			shift;		// quotient below 1.0
	logic [FRAC_W:0]	mant;		// aligned, unrounded
	logic			guard;		// first dropped bit
	logic			rnd_up;		// nearest even increment
	logic [FRAC_W+1:0]	rnd_sum;	// with carry bit
	logic			carry;		// rounded up to 2.0
	logic [FRAC_W:0]	frac_rnd;	// rounded significand
	logic signed [CW+1:0]	adj;		// final adjustment

	//////////////////////////////
	// align and round
	//////////////////////////////

	always_comb begin
		shift = ~i_q[FRAC_W+1];
		mant = shift ? i_q[FRAC_W:0] : i_q[FRAC_W+1:1];
		guard = shift ? 1'b0 : i_q[0];	// shifted case has no bit left below
		rnd_up = guard & (i_rem_nz | mant[0]);	// tie goes to even
		rnd_sum = {1'b0, mant} + {{(FRAC_W+1){1'b0}}, rnd_up};
		carry = rnd_sum[FRAC_W+1];
		frac_rnd = carry ? {1'b1, {FRAC_W{1'b0}}} : rnd_sum[FRAC_W:0];	// back to 1.0
		adj = i_lz_diff - $signed({1'b0, shift}) + $signed({1'b0, carry});
	end

	//////////////////////////////
	// result register
	//////////////////////////////

	// divide by zero wins over zero dividend
	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			o_done <= 1'b0;
			o_frac_q <= '0;
			o_exp_adj <= '0;
			o_dz <= 1'b0;
			o_zero <= 1'b0;
		end else begin
			o_done <= i_vld;
			if (i_vld) begin
				if (i_cls_b == cls_zero) begin
					o_frac_q <= '0;		// infinity to the exp logic
					o_exp_adj <= '0;
					o_dz <= 1'b1;
					o_zero <= 1'b0;
				end else if (i_cls_a == cls_zero) begin
					o_frac_q <= '0;
					o_exp_adj <= '0;
					o_dz <= 1'b0;
					o_zero <= 1'b1;
				end else begin
					o_frac_q <= frac_rnd;
					o_exp_adj <= adj;
					o_dz <= 1'b0;
					o_zero <= 1'b0;
				end
			end
		end
	end

	a_flags_excl: assert property (@(posedge rclk) disable iff (!i_rst_n)
		!(o_dz && o_zero))
		else $error("divide by zero and zero result both set");

endmodule

//--- fdiv_frac_top.sv
`timescale 1ns/1ps

module fdiv_frac_top
	import fdiv_pkg::*;
#(
	parameter int FRAC_W = 52,			// fraction bits
	localparam int CW = fdiv_cnt_w(FRAC_W)		// lead zero count width
) (
	input  logic			rclk,		// global clock
	input  logic			i_rst_n,	// sync reset, active low
	input  logic			i_start,	// start strobe
	input  logic [FRAC_W:0]		i_frac_a,	// dividend significand
	input  logic [FRAC_W:0]		i_frac_b,	// divisor significand
	output logic			o_busy,		// op in flight
	output logic			o_done,		// result pulse
	output logic [FRAC_W:0]		o_frac_q,	// quotient significand
	output logic signed [CW+1:0]	o_exp_adj,	// exponent adjustment
	output logic			o_dz,		// divide by zero
	output logic			o_zero		// zero result
);

	//////////////////////////////
	// stage wiring
	//////////////////////////////

	logic			norm_pend;	// capture cycle
	logic			norm_vld;
	logic [FRAC_W:0]	norm_a;
	logic [FRAC_W:0]	norm_b;
	logic signed [CW:0]	norm_lz_diff;
	fdiv_cls_e		norm_cls_a;
	fdiv_cls_e		norm_cls_b;
	logic			iter_busy;	// also gates new starts
	logic			iter_vld;
	logic [FRAC_W+1:0]	iter_q;
	logic			iter_rem_nz;
	logic signed [CW:0]	iter_lz_diff;
	fdiv_cls_e		iter_cls_a;
	fdiv_cls_e		iter_cls_b;

	assign o_busy = iter_busy;

	fdiv_norm_stage #(.FRAC_W(FRAC_W)) u_norm (
		.rclk		(rclk),
		.i_rst_n	(i_rst_n),
		.i_start	(i_start),
		.i_busy		(iter_busy),
		.i_frac_a	(i_frac_a),
		.i_frac_b	(i_frac_b),
		.o_pend		(norm_pend),
		.o_vld		(norm_vld),
		.o_norm_a	(norm_a),
		.o_norm_b	(norm_b),
		.o_lz_diff	(norm_lz_diff),
		.o_cls_a	(norm_cls_a),
		.o_cls_b	(norm_cls_b)
	);

	fdiv_iter_stage #(.FRAC_W(FRAC_W)) u_iter (
		.rclk		(rclk),
		.i_rst_n	(i_rst_n),
		.i_pend		(norm_pend),
		.i_vld		(norm_vld),
		.i_norm_a	(norm_a),
		.i_norm_b	(norm_b),
		.i_lz_diff	(norm_lz_diff),
		.i_cls_a	(norm_cls_a),
		.i_cls_b	(norm_cls_b),
		.o_busy		(iter_busy),
		.o_vld		(iter_vld),
		.o_q		(iter_q),
		.o_rem_nz	(iter_rem_nz),
		.o_lz_diff	(iter_lz_diff),
		.o_cls_a	(iter_cls_a),
		.o_cls_b	(iter_cls_b)
	);

	fdiv_round_stage #(.FRAC_W(FRAC_W)) u_round (
		.rclk		(rclk),
		.i_rst_n	(i_rst_n),
		.i_vld		(iter_vld),
		.i_q		(iter_q),
		.i_rem_nz	(iter_rem_nz),
		.i_lz_diff	(iter_lz_diff),
		.i_cls_a	(iter_cls_a),
		.i_cls_b	(iter_cls_b),
		.o_done		(o_done),
		.o_frac_q	(o_frac_q),
		.o_exp_adj	(o_exp_adj),
		.o_dz		(o_dz),
		.o_zero		(o_zero)
	);

endmodule

//--- tb_fdiv_frac.sv
`timescale 1ns/1ps

module tb_fdiv_frac
	import fdiv_pkg::*;
;

	localparam int FW = 23;				// fraction bits under test
	localparam int CW = fdiv_cnt_w(FW);		// count width in the dut
	localparam int DONE_LAT = FW + 5;		// start edge to done edge
	localparam int CYC_LIMIT = 400 * (FW + 8) + 100;	// watchdog bound

	logic			rclk = 1'b0;
	logic			i_rst_n = 1'b0;
	logic			i_start = 1'b0;
	logic [FW:0]		i_frac_a = '0;
	logic [FW:0]		i_frac_b = '0;
	logic			o_busy;
	logic			o_done;
	logic [FW:0]		o_frac_q;
	logic signed [CW+1:0]	o_exp_adj;
	logic			o_dz;
	logic			o_zero;

	int		seed = 32'hc87b_7143;	// fixed stimulus seed
	int		cycles = 0;		// watchdog count
	int		n_ops = 0;		// completed operations
	int		value_errs = 0;		// result mismatches
	int		timing_errs = 0;	// protocol mismatches
	int		op_cnt = 0;		// cycles since accepted start, 0 idle
	logic		model_busy;		// expected o_busy
	logic [FW:0]	exp_frac = '0;		// expected o_frac_q
	int		exp_adj = 0;		// expected o_exp_adj
	logic		exp_dz = 1'b0;
	logic		exp_zero = 1'b0;
	logic		exp_sticky = 1'b0;	// expected remainder flag

	fdiv_frac_top #(.FRAC_W(FW)) u_dut (
		.rclk		(rclk),
		.i_rst_n	(i_rst_n),
		.i_start	(i_start),
		.i_frac_a	(i_frac_a),
		.i_frac_b	(i_frac_b),
		.o_busy		(o_busy),
		.o_done		(o_done),
		.o_frac_q	(o_frac_q),
		.o_exp_adj	(o_exp_adj),
		.o_dz		(o_dz),
		.o_zero		(o_zero)
	);

	always #2 rclk = ~rclk;				// 4 ns period

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic int lead_zeros(input logic [FW:0] v);
		int n;
		n = 0;
		for (int i = FW; i >= 0; i--) begin
			if (v[i])
				return n;
			n++;
		end
		return n;				// zero operand
	endfunction

	// integer divide of the normalized operands, then align and round
	task automatic predict(input logic [FW:0] a, input logic [FW:0] b,
			output logic [FW:0] frac, output int adj, output logic dz,
			output logic zr, output logic sticky);
		int		lza;
		int		lzb;
		int		sh;
		int		cy;
		logic [63:0]	num;
		logic [63:0]	nb;
		logic [63:0]	q;
		logic [63:0]	mant;
		logic		rnz;
		logic		grd;
		logic		up;
		dz = (b == '0);				// divisor zero wins
		zr = !dz && (a == '0);
		frac = '0;
		adj = 0;
		sticky = 1'b0;
		if (!dz && !zr) begin
			lza = lead_zeros(a);
			lzb = lead_zeros(b);
			num = (64'(a) << lza) << (FW + 1);	// quotient scaled to FW+2 bits
			nb = 64'(b) << lzb;
			q = num / nb;
			rnz = (num % nb) != 0;
			sh = q[FW+1] ? 0 : 1;		// below 1.0
			mant = (sh != 0) ? q : q >> 1;
			grd = (sh != 0) ? 1'b0 : q[0];	// no bit left after the shift
			up = grd && (rnz || mant[0]);	// nearest even
			mant = mant + 64'(up);
			cy = mant[FW+1] ? 1 : 0;
			if (cy != 0)
				mant = 64'(1) << FW;	// renormalize to 1.0
			frac = mant[FW:0];
			adj = lzb - lza - sh + cy;
			sticky = rnz;
		end
	endtask

	//////////////////////////////
	// start tracking
	//////////////////////////////

	assign model_busy = (op_cnt != 0) && (op_cnt < DONE_LAT);

	always @(posedge rclk) begin : track
		logic [FW:0]	f;
		int		adj;
		logic		dz;
		logic		zr;
		logic		st;
		if (!i_rst_n) begin
			op_cnt <= 0;
		end else if (i_start && !model_busy) begin	// accepted start
			predict(i_frac_a, i_frac_b, f, adj, dz, zr, st);
			exp_frac <= f;
			exp_adj <= adj;
			exp_dz <= dz;
			exp_zero <= zr;
			exp_sticky <= st;
			op_cnt <= 1;
		end else if (op_cnt == DONE_LAT) begin
			op_cnt <= 0;
		end else if (op_cnt != 0) begin
			op_cnt <= op_cnt + 1;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_reset_idle: assert property (@(posedge rclk) $rose(i_rst_n) |->
		!o_busy && !o_done && !o_dz && !o_zero && o_frac_q == '0)
		else begin
			timing_errs++;
			$display("CHECK FAILED @%0t ns: outputs not idle after reset", $time);
		end

	a_busy_level: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_busy == model_busy)
		else begin
			timing_errs++;
			$display("CHECK FAILED @%0t ns: o_busy %b, expected %b", $time,
				$sampled(o_busy), $sampled(model_busy));
		end

	a_done_cycle: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_done == (op_cnt == DONE_LAT))
		else begin
			timing_errs++;
			$display("CHECK FAILED @%0t ns: o_done %b at cycle %0d after start",
				$time, $sampled(o_done), $sampled(op_cnt));
		end

	a_frac: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_done |-> o_frac_q == exp_frac)
		else begin
			value_errs++;
			$display("CHECK FAILED @%0t ns: o_frac_q %h, expected %h", $time,
				$sampled(o_frac_q), $sampled(exp_frac));
		end

	a_adj: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_done |-> o_exp_adj == exp_adj)
		else begin
			value_errs++;
			$display("CHECK FAILED @%0t ns: o_exp_adj %0d, expected %0d", $time,
				$sampled(o_exp_adj), $sampled(exp_adj));
		end

	a_flags: assert property (@(posedge rclk) disable iff (!i_rst_n)
		o_done |-> o_dz == exp_dz && o_zero == exp_zero)
		else begin
			value_errs++;
			$display("CHECK FAILED @%0t ns: dz/zero %b%b, expected %b%b", $time,
				$sampled(o_dz), $sampled(o_zero), $sampled(exp_dz),
				$sampled(exp_zero));
		end

	// remainder flag only means something for a real quotient
	a_sticky: assert property (@(posedge rclk) disable iff (!i_rst_n)
		(o_done && !exp_dz && !exp_zero) |-> u_dut.iter_rem_nz == exp_sticky)
		else begin
			value_errs++;
			$display("CHECK FAILED @%0t ns: remainder flag %b, expected %b", $time,
				$sampled(u_dut.iter_rem_nz), $sampled(exp_sticky));
		end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic run_op(input logic [FW:0] a, input logic [FW:0] b);
		@(posedge rclk);
		i_start <= 1'b1;
		i_frac_a <= a;
		i_frac_b <= b;
		@(posedge rclk);			// accept edge
		i_start <= 1'b0;
		while (!o_done)
			@(posedge rclk);
		n_ops++;
	endtask

	// extra starts land mid-loop and near the end of the op
	task automatic run_busy_op(input logic [FW:0] a, input logic [FW:0] b,
			input logic [FW:0] a2, input logic [FW:0] b2);
		@(posedge rclk);
		i_start <= 1'b1;
		i_frac_a <= a;
		i_frac_b <= b;
		@(posedge rclk);
		i_start <= 1'b0;
		repeat (2) @(posedge rclk);
		i_start <= 1'b1;
		i_frac_a <= a2;
		i_frac_b <= b2;
		@(posedge rclk);
		i_start <= 1'b0;
		repeat (FW) @(posedge rclk);
		i_start <= 1'b1;			// sampled on the edge that raises done
		@(posedge rclk);
		i_start <= 1'b0;
		while (!o_done)
			@(posedge rclk);
		n_ops++;
	endtask

	// normal, or a normal shifted down into a denormal
	task automatic make_operand(output logic [FW:0] v);
		int kind;
		int sh;
		kind = $unsigned($random(seed)) % 3;
		sh = 1 + $unsigned($random(seed)) % FW;
		v = {1'b1, FW'($random(seed))};
		if (kind == 2)
			v = v >> sh;
	endtask

	initial begin : watchdog
		while (cycles < CYC_LIMIT) begin
			@(posedge rclk);
			cycles++;
		end
		$display("TIMEOUT: run did not finish within %0d cycles", CYC_LIMIT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main
		logic [FW:0] a;
		logic [FW:0] b;
		repeat (5) @(posedge rclk);
		i_rst_n <= 1'b1;
		run_op(24'hc00000, 24'h800000);	// 1.5 / 1.0
		run_op(24'h800000, 24'h800000);	// 1.0 / 1.0
		run_op(24'h800000, 24'hc00000);	// 1.0 / 1.5, shift
		run_op(24'hffffff, 24'h800000);
		run_op(24'hffffff, 24'h800001);	// close to 2.0
		run_op(24'h800000, 24'hffffff);
		run_op(24'h400000, 24'h800000);	// denormal dividend
		run_op(24'h800000, 24'h000001);	// smallest divisor
		run_op(24'h000003, 24'h0000a5);	// both denormal
		run_op(24'h800000, 24'h000000);	// divide by zero
		run_op(24'h000000, 24'hc00000);	// zero dividend
		run_op(24'h000000, 24'h000000);	// dz only
		run_busy_op(24'ha00000, 24'hc00000, 24'h800000, 24'h000000);
		run_busy_op(24'h000000, 24'h900000, 24'hffffff, 24'h800000);
		for (int i = 0; i < 300; i++) begin
			make_operand(a);
			make_operand(b);
			run_op(a, b);
		end
		repeat (3) @(posedge rclk);		// let the last checks fire
		$display("summary: %0d ops, %0d value errors, %0d timing errors",
			n_ops, value_errs, timing_errs);
		if (value_errs == 0 && timing_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- compile.f
fdiv_pkg.sv
fdiv_lead0.sv
fdiv_norm_stage.sv
fdiv_iter_stage.sv
fdiv_round_stage.sv
fdiv_frac_top.sv
tb_fdiv_frac.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_fdiv_frac -o sim_fdiv_frac
./obj_dir/sim_fdiv_frac | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
